// File: regfile_subsystem.f
+incdir+verilog
verilog/regfile_pkg.sv
verilog/toggle_memory_set.sv
verilog/lutram_1w_mr.sv
verilog/register_file.sv
verilog/regfile_subsystem.sv
tb/regfile_properties.sv
tb/regfile_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= regfile_tb
FILELIST  ?= regfile_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS) verilog/regfile_cfg.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "Run ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/regfile_tb.sv
`timescale 1ns/1ns
`include "regfile_cfg.svh"

module regfile_tb;

    logic                    clk;
    logic                    reset;
    regfile_pkg::phys_addr_t decode_phys_rs_addr [`RF_READ_PORTS];
    regfile_pkg::wb_group_t  decode_rs_wb_group  [`RF_READ_PORTS];
    regfile_pkg::phys_addr_t decode_phys_rd_addr;
    regfile_pkg::rs_addr_t   decode_rd_addr;
    logic                    decode_uses_rd;
    logic                    decode_advance;
    regfile_pkg::phys_addr_t issue_phys_rs_addr  [`RF_READ_PORTS];
    logic                    issue_inuse         [`RF_READ_PORTS];
    logic [`RF_DATA_W-1:0]   issue_data          [`RF_READ_PORTS];
    regfile_pkg::phys_addr_t issue_phys_rd_addr;
    logic                    issue_single_cycle_or_flush;
    logic                    commit_valid        [`RF_NUM_WB_GROUPS];
    logic [`RF_DATA_W-1:0]   commit_data         [`RF_NUM_WB_GROUPS];
    regfile_pkg::phys_addr_t wb_phys_addr        [`RF_NUM_WB_GROUPS];
    logic                    fetch_flush;
    logic                    writeback_suppress;
    logic                    init_clear;
    logic [31:0]             rng;

    regfile_subsystem dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Whole-run limit
    initial begin
        #20000;
        $display("SIMULATION FAILED");
        $fatal(1, "global timeout, the test sequence did not finish");
    end

    // First assertion failure ends the run
    always @(posedge clk) begin
        if (dut_i.props_i.error_count != 0) begin
            $display("SIMULATION FAILED");
            $fatal(1, "an assertion check failed");
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Nonzero register with the group in bit 0
    function automatic regfile_pkg::phys_addr_t random_addr();
        rng = xorshift32(rng);
        return (rng[5:0] == '0) ? 6'd1 : rng[5:0];
    endfunction

    task automatic idle_strobes();
        decode_advance              <= 1'b0;
        decode_uses_rd              <= 1'b0;
        issue_single_cycle_or_flush <= 1'b0;
        fetch_flush                 <= 1'b0;
        writeback_suppress          <= 1'b0;
        init_clear                  <= 1'b0;
        commit_valid[0]             <= 1'b0;
        commit_valid[1]             <= 1'b0;
    endtask

    task automatic commit_write(input regfile_pkg::phys_addr_t addr, input logic [31:0] data,
                                input logic suppress);
        @(posedge clk);
        commit_valid[addr[0]] <= 1'b1;
        commit_data[addr[0]]  <= data;
        wb_phys_addr[addr[0]] <= addr;
        writeback_suppress    <= suppress;
        @(posedge clk);
        idle_strobes();
    endtask

    // Issue ports follow the decoded sources
    task automatic decode_read(input regfile_pkg::phys_addr_t a0, input regfile_pkg::phys_addr_t a1);
        @(posedge clk);
        decode_phys_rs_addr[0] <= a0;
        decode_phys_rs_addr[1] <= a1;
        decode_rs_wb_group[0]  <= a0[0];
        decode_rs_wb_group[1]  <= a1[0];
        issue_phys_rs_addr[0]  <= a0;
        issue_phys_rs_addr[1]  <= a1;
        decode_advance         <= 1'b1;
        @(posedge clk);
        idle_strobes();
        @(posedge clk);
    endtask

    task automatic decode_dest(input regfile_pkg::phys_addr_t p, input regfile_pkg::rs_addr_t rd,
                               input logic flush);
        @(posedge clk);
        decode_phys_rd_addr <= p;
        decode_rd_addr      <= rd;
        decode_uses_rd      <= 1'b1;
        fetch_flush         <= flush;
        decode_advance      <= 1'b1;
        @(posedge clk);
        idle_strobes();
    endtask

    task automatic watch_addr(input regfile_pkg::phys_addr_t p);
        @(posedge clk);
        issue_phys_rs_addr[0] <= p;
        issue_phys_rs_addr[1] <= p;
    endtask

    task automatic pulse(input int which, input regfile_pkg::phys_addr_t p);
        @(posedge clk);
        issue_phys_rd_addr <= p;
        if (which == 0)
            init_clear <= 1'b1;
        else
            issue_single_cycle_or_flush <= 1'b1;
        @(posedge clk);
        idle_strobes();
    endtask

    // Sampled on the falling edge, away from the register updates
    task automatic wait_inuse(input int port, input logic value);
        @(negedge clk);
        for (int n = 0; n < 20 && issue_inuse[port] !== value; n++)
            @(negedge clk);
        if (issue_inuse[port] !== value) begin
            $display("SIMULATION FAILED");
            $fatal(1, "timeout waiting for issue_inuse[%0d] to become %0b", port, value);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        regfile_pkg::phys_addr_t a;
        rng = 32'd72759;
        reset = 1'b1;
        decode_phys_rd_addr = '0;
        decode_rd_addr = '0;
        issue_phys_rd_addr = '0;
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            decode_phys_rs_addr[i] = '0;
            decode_rs_wb_group[i] = '0;
            issue_phys_rs_addr[i] = '0;
        end
        for (int g = 0; g < `RF_NUM_WB_GROUPS; g++) begin
            commit_valid[g] = 1'b0;
            commit_data[g] = '0;
            wb_phys_addr[g] = '0;
        end
        {decode_uses_rd, decode_advance, issue_single_cycle_or_flush} = '0;
        {fetch_flush, writeback_suppress, init_clear} = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Fill every register, even ones on group 0, odd ones on group 1
        for (int r = 0; r < `RF_NUM_PHYS_REGS; r += 2) begin
            @(posedge clk);
            rng = xorshift32(rng);
            commit_data[0] <= rng;
            rng = xorshift32(rng);
            commit_data[1] <= rng;
            wb_phys_addr[0] <= 6'(r);
            wb_phys_addr[1] <= 6'(r + 1);
            commit_valid[0] <= 1'b1;
            commit_valid[1] <= 1'b1;
        end
        @(posedge clk);
        idle_strobes();
        pulse(0, '0);

        // Bank reads after a commit
        for (int k = 0; k < 8; k++) begin
            a = random_addr();
            rng = xorshift32(rng);
            commit_write(a, rng, 1'b0);
            // A group 1 commit also flips the in-use bit
            // Run-time clear so the read comes from the bank
            pulse(0, '0);
            decode_read(a, random_addr());
        end

        // Register 0 reads zero
        commit_write('0, 32'hdead_beef, 1'b0);
        decode_read('0, '0);

        // Set by decode, cleared by group 1 commit
        watch_addr(6'd9);
        decode_dest(6'd9, 5'd5, 1'b0);
        wait_inuse(0, 1'b1);
        commit_write(6'd9, 32'h1234_5678, 1'b0);
        wait_inuse(0, 1'b0);
        // Cleared by the single cycle strobe
        watch_addr(6'd10);
        decode_dest(6'd10, 5'd6, 1'b0);
        wait_inuse(1, 1'b1);
        pulse(1, 6'd10);
        wait_inuse(1, 1'b0);
        // Flush and x0 never set
        watch_addr(6'd11);
        decode_dest(6'd11, 5'd7, 1'b1);
        decode_dest(6'd11, 5'd0, 1'b0);
        repeat (3) @(posedge clk);
        // Run-time clear
        watch_addr(6'd12);
        decode_dest(6'd12, 5'd8, 1'b0);
        wait_inuse(0, 1'b1);
        pulse(0, '0);
        wait_inuse(0, 1'b0);

        // Suppressed commit keeps the older value
        commit_write(6'd20, 32'h0bad_f00d, 1'b0);
        commit_write(6'd20, 32'h5555_aaaa, 1'b1);
        decode_read(6'd20, 6'd20);

        // Bypass from the group 1 commit
        decode_dest(6'd13, 5'd9, 1'b0);
        decode_read(6'd13, 6'd13);
        wait_inuse(0, 1'b1);
        commit_write(6'd13, 32'hcafe_0013, 1'b0);
        wait_inuse(0, 1'b0);
        repeat (3) @(posedge clk);
        pulse(0, '0);

        // Random mix on both groups and ports
        for (int c = 0; c < 300; c++) begin
            @(posedge clk);
            rng = xorshift32(rng);
            commit_valid[0] <= rng[0];
            commit_valid[1] <= rng[1];
            writeback_suppress <= (rng[4:2] == 3'd0);
            decode_advance <= rng[5];
            wb_phys_addr[0] <= {rng[10:6], 1'b0};
            wb_phys_addr[1] <= {rng[15:11], 1'b1};
            if (rng[5]) begin
                for (int i = 0; i < `RF_READ_PORTS; i++) begin
                    a = random_addr();
                    decode_phys_rs_addr[i] <= a;
                    decode_rs_wb_group[i] <= a[0];
                    issue_phys_rs_addr[i] <= a;
                end
            end
            rng = xorshift32(rng);
            commit_data[0] <= rng;
            rng = xorshift32(rng);
            commit_data[1] <= rng;
        end
        @(posedge clk);
        idle_strobes();
        repeat (4) @(posedge clk);

        if (dut_i.props_i.error_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "assertion checks reported errors");
        end
    end

endmodule

// File: tb/regfile_properties.sv
`timescale 1ns/1ns
`include "regfile_cfg.svh"

module regfile_properties (
    input logic                    clk,
    input logic                    reset,
    input regfile_pkg::phys_addr_t decode_phys_rs_addr [`RF_READ_PORTS],
    input regfile_pkg::wb_group_t  decode_rs_wb_group  [`RF_READ_PORTS],
    input regfile_pkg::phys_addr_t decode_phys_rd_addr,
    input regfile_pkg::rs_addr_t   decode_rd_addr,
    input logic                    decode_uses_rd,
    input logic                    decode_advance,
    input regfile_pkg::phys_addr_t issue_phys_rs_addr  [`RF_READ_PORTS],
    input logic                    issue_inuse         [`RF_READ_PORTS],
    input logic [`RF_DATA_W-1:0]   issue_data          [`RF_READ_PORTS],
    input regfile_pkg::phys_addr_t issue_phys_rd_addr,
    input logic                    issue_single_cycle_or_flush,
    input logic                    commit_valid        [`RF_NUM_WB_GROUPS],
    input logic [`RF_DATA_W-1:0]   commit_data         [`RF_NUM_WB_GROUPS],
    input regfile_pkg::phys_addr_t wb_phys_addr        [`RF_NUM_WB_GROUPS],
    input logic                    fetch_flush,
    input logic                    writeback_suppress,
    input logic                    init_clear
);

    // Shadow register contents, one group per address
    logic [`RF_DATA_W-1:0]        shadow_data [`RF_NUM_PHYS_REGS];
    logic [`RF_NUM_PHYS_REGS-1:0] shadow_inuse;
    logic [`RF_NUM_PHYS_REGS-1:0] flip;

    // Expected operand per port, latched at decode
    logic                    exp_valid  [`RF_READ_PORTS];
    logic                    exp_bypass [`RF_READ_PORTS];
    logic                    byp_seen   [`RF_READ_PORTS];
    regfile_pkg::phys_addr_t exp_addr   [`RF_READ_PORTS];
    regfile_pkg::wb_group_t  exp_group  [`RF_READ_PORTS];
    logic [`RF_DATA_W-1:0]   exp_data   [`RF_READ_PORTS];
    logic [`RF_DATA_W-1:0]   exp_byp    [`RF_READ_PORTS];

    int unsigned error_count = 0;

    //////////////////////////////
    // Shadow model
    //////////////////////////////

    // Bits flipped this cycle by the three toggle rules
    always_comb begin
        flip = '0;
        if (decode_advance && decode_uses_rd && decode_rd_addr != '0 && !fetch_flush)
            flip[decode_phys_rd_addr] = 1'b1;
        if (issue_single_cycle_or_flush)
            flip[issue_phys_rd_addr] = ~flip[issue_phys_rd_addr];
        if (commit_valid[1] && wb_phys_addr[1] != '0)
            flip[wb_phys_addr[1]] = ~flip[wb_phys_addr[1]];
    end

    always_ff @(posedge clk) begin
        if (reset || init_clear) begin
            shadow_inuse <= '0;
        end else begin
            shadow_inuse <= shadow_inuse ^ flip;
        end
        for (int g = 0; g < `RF_NUM_WB_GROUPS; g++) begin
            if (commit_valid[g] && !writeback_suppress)
                shadow_data[wb_phys_addr[g]] <= commit_data[g];
        end
    end

    // Bypass target is the group 1 commit that hits the decoded register
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            if (reset) begin
                exp_valid[i] <= 1'b0;
                byp_seen[i]  <= 1'b0;
            end else if (decode_advance) begin
                exp_valid[i]  <= 1'b1;
                exp_addr[i]   <= decode_phys_rs_addr[i];
                exp_group[i]  <= decode_rs_wb_group[i];
                exp_bypass[i] <= shadow_inuse[decode_phys_rs_addr[i]];
                exp_data[i]   <= (decode_phys_rs_addr[i] == '0) ?
                                 '0 : shadow_data[decode_phys_rs_addr[i]];
                byp_seen[i]   <= 1'b0;
            end else if (exp_bypass[i] && exp_group[i] == 1'b1 && commit_valid[1]
                         && wb_phys_addr[1] == exp_addr[i]) begin
                exp_byp[i]  <= commit_data[1];
                byp_seen[i] <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Checks per port
    //////////////////////////////

    for (genvar i = 0; i < `RF_READ_PORTS; i++) begin : port_checks
        inuse_track: assert property (@(posedge clk) disable iff (reset)
            issue_inuse[i] == shadow_inuse[issue_phys_rs_addr[i]])
        else begin
            error_count++;
            $error("[ERROR] inuse_track port %0d expected %0b actual %0b", i,
                $sampled(shadow_inuse[issue_phys_rs_addr[i]]), $sampled(issue_inuse[i]));
        end

        bank_read: assert property (@(posedge clk) disable iff (reset)
            exp_valid[i] && !exp_bypass[i] && exp_addr[i] != '0
            |-> issue_data[i] == exp_data[i])
        else begin
            error_count++;
            $error("[ERROR] bank_read port %0d expected %h actual %h", i,
                $sampled(exp_data[i]), $sampled(issue_data[i]));
        end

        zero_reg: assert property (@(posedge clk) disable iff (reset)
            exp_valid[i] && !exp_bypass[i] && exp_addr[i] == '0 |-> issue_data[i] == '0)
        else begin
            error_count++;
            $error("[ERROR] zero_reg port %0d expected 0 actual %h", i, $sampled(issue_data[i]));
        end

        // Operand frozen once the register goes free
        bypass_value: assert property (@(posedge clk) disable iff (reset)
            byp_seen[i] && !issue_inuse[i] |-> issue_data[i] == exp_byp[i])
        else begin
            error_count++;
            $error("[ERROR] bypass_value port %0d expected %h actual %h", i,
                $sampled(exp_byp[i]), $sampled(issue_data[i]));
        end

        init_free: assert property (@(posedge clk) disable iff (reset)
            init_clear |=> !issue_inuse[i])
        else begin
            error_count++;
            $error("[ERROR] init_free port %0d expected 0 actual 1", i);
        end
    end

endmodule

bind regfile_subsystem regfile_properties props_i (.*);

// File: verilog/regfile_subsystem.sv
`timescale 1ns/1ns
`include "regfile_cfg.svh"

module regfile_subsystem (
    input  logic                    clk,
    input  logic                    reset,

    // Decode side
    input  regfile_pkg::phys_addr_t decode_phys_rs_addr [`RF_READ_PORTS],
    input  regfile_pkg::wb_group_t  decode_rs_wb_group  [`RF_READ_PORTS],
    input  regfile_pkg::phys_addr_t decode_phys_rd_addr,
    input  regfile_pkg::rs_addr_t   decode_rd_addr,
    input  logic                    decode_uses_rd,
    input  logic                    decode_advance,

    // Issue side
    input  regfile_pkg::phys_addr_t issue_phys_rs_addr  [`RF_READ_PORTS],
    output logic                    issue_inuse         [`RF_READ_PORTS],
    output logic [`RF_DATA_W-1:0]   issue_data          [`RF_READ_PORTS],
    input  regfile_pkg::phys_addr_t issue_phys_rd_addr,
    input  logic                    issue_single_cycle_or_flush,

    // Commit per writeback group
    input  logic                    commit_valid        [`RF_NUM_WB_GROUPS],
    input  logic [`RF_DATA_W-1:0]   commit_data         [`RF_NUM_WB_GROUPS],
    input  regfile_pkg::phys_addr_t wb_phys_addr        [`RF_NUM_WB_GROUPS],

    // Control from the rest of the core
    input  logic                    fetch_flush,
    input  logic                    writeback_suppress,
    input  logic                    init_clear
);

    //////////////////////////////
    // Register file core
    //////////////////////////////

    register_file regfile_i (
        .clk                         (clk),
        .reset                       (reset),
        .decode_phys_rs_addr         (decode_phys_rs_addr),
        .decode_rs_wb_group          (decode_rs_wb_group),
        .decode_phys_rd_addr         (decode_phys_rd_addr),
        .decode_rd_addr              (decode_rd_addr),
        .decode_uses_rd              (decode_uses_rd),
        .decode_advance              (decode_advance),
        .issue_phys_rs_addr          (issue_phys_rs_addr),
        .issue_inuse                 (issue_inuse),
        .issue_data                  (issue_data),
        .issue_phys_rd_addr          (issue_phys_rd_addr),
        .issue_single_cycle_or_flush (issue_single_cycle_or_flush),
        .commit_valid                (commit_valid),
        .commit_data                 (commit_data),
        .wb_phys_addr                (wb_phys_addr),
        .fetch_flush                 (fetch_flush),
        .writeback_suppress          (writeback_suppress),
        .init_clear                  (init_clear)
    );

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ns
`include "regfile_cfg.svh"

module register_file (
    input  logic                    clk,
    input  logic                    reset,

    // Decode side
    input  regfile_pkg::phys_addr_t decode_phys_rs_addr [`RF_READ_PORTS],
    input  regfile_pkg::wb_group_t  decode_rs_wb_group  [`RF_READ_PORTS],
    input  regfile_pkg::phys_addr_t decode_phys_rd_addr,
    input  regfile_pkg::rs_addr_t   decode_rd_addr,
    input  logic                    decode_uses_rd,
    input  logic                    decode_advance,

    // Issue side
    input  regfile_pkg::phys_addr_t issue_phys_rs_addr  [`RF_READ_PORTS],
    output logic                    issue_inuse         [`RF_READ_PORTS],
    output logic [`RF_DATA_W-1:0]   issue_data          [`RF_READ_PORTS],
    input  regfile_pkg::phys_addr_t issue_phys_rd_addr,
    input  logic                    issue_single_cycle_or_flush,

    // Commit, one set per writeback group
    input  logic                    commit_valid        [`RF_NUM_WB_GROUPS],
    input  logic [`RF_DATA_W-1:0]   commit_data         [`RF_NUM_WB_GROUPS],
    input  regfile_pkg::phys_addr_t wb_phys_addr        [`RF_NUM_WB_GROUPS],

    // Control
    input  logic                    fetch_flush,
    input  logic                    writeback_suppress,
    input  logic                    init_clear
);

    // Decode toggle, single cycle or flush, then one per commit group
    localparam int NUM_TOGGLE_PORTS = 1 + `RF_NUM_WB_GROUPS;
    // Decode lookups first, issue lookups after
    localparam int NUM_INUSE_READS  = 2 * `RF_READ_PORTS;

    regfile_pkg::phys_addr_t inuse_read_addr [NUM_INUSE_READS];
    logic                    inuse           [NUM_INUSE_READS];
    logic                    decode_inuse    [`RF_READ_PORTS];
    logic                    toggle          [NUM_TOGGLE_PORTS];
    regfile_pkg::phys_addr_t toggle_addr     [NUM_TOGGLE_PORTS];

    // Bank read data, indexed by group then port
    logic [`RF_DATA_W-1:0] bank_rd_data   [`RF_NUM_WB_GROUPS][`RF_READ_PORTS];
    // Operands registered at decode
    logic [`RF_DATA_W-1:0] rs_data_r      [`RF_READ_PORTS];
    // Commit capture for bypass, group then port
    logic [`RF_DATA_W-1:0] commit_rs_data [`RF_NUM_WB_GROUPS][`RF_READ_PORTS];
    // Operand source per port
    regfile_pkg::operand_src_t issue_sel  [`RF_READ_PORTS];

    //////////////////////////////
    // In-use tracking
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            inuse_read_addr[i]                  = decode_phys_rs_addr[i];
            inuse_read_addr[i + `RF_READ_PORTS] = issue_phys_rs_addr[i];
            decode_inuse[i]                     = inuse[i];
            issue_inuse[i]                      = inuse[i + `RF_READ_PORTS];
        end

        // New destination marked in use, x0 and flushed decodes skipped
        toggle[0]      = decode_advance & decode_uses_rd & (|decode_rd_addr) & ~fetch_flush;
        toggle_addr[0] = decode_phys_rd_addr;

        // Single cycle results and flushed ops free their register at issue
        toggle[1]      = issue_single_cycle_or_flush;
        toggle_addr[1] = issue_phys_rd_addr;

        // Multi cycle groups free their register at commit
        for (int g = 1; g < `RF_NUM_WB_GROUPS; g++) begin
            toggle[g + 1]      = commit_valid[g] & (|wb_phys_addr[g]);
            toggle_addr[g + 1] = wb_phys_addr[g];
        end
    end

    toggle_memory_set #(
        .DEPTH           (`RF_NUM_PHYS_REGS),
        .NUM_WRITE_PORTS (NUM_TOGGLE_PORTS),
        .NUM_READ_PORTS  (NUM_INUSE_READS)
    ) inuse_tracker (
        .clk         (clk),
        .reset       (reset),
        .init_clear  (init_clear),
        .toggle      (toggle),
        .toggle_addr (toggle_addr),
        .read_addr   (inuse_read_addr),
        .in_use      (inuse)
    );

    //////////////////////////////
    // Register banks
    //////////////////////////////

    // One LUTRAM bank per group, all read with the decode addresses
    generate for (genvar g = 0; g < `RF_NUM_WB_GROUPS; g++) begin : bank_gen
        lutram_1w_mr #(
            .WIDTH          (`RF_DATA_W),
            .DEPTH          (`RF_NUM_PHYS_REGS),
            .NUM_READ_PORTS (`RF_READ_PORTS)
        ) bank (
            .clk          (clk),
            .waddr        (wb_phys_addr[g]),
            .raddr        (decode_phys_rs_addr),
            .ram_write    (commit_valid[g] & ~writeback_suppress),
            .new_ram_data (commit_data[g]),
            .ram_data_out (bank_rd_data[g])
        );
    end endgenerate

    //////////////////////////////
    // Decode operand registers
    //////////////////////////////

    // Held while decode stalls
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            if (decode_advance) begin
                if (decode_phys_rs_addr[i] == '0) begin
                    rs_data_r[i] <= '0;
                end else begin
                    rs_data_r[i] <= bank_rd_data[decode_rs_wb_group[i]][i];
                end
            end
        end
    end

    // Still in use at decode means the value comes later through bypass
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            if (reset) begin
                issue_sel[i] <= regfile_pkg::SRC_BANK;
            end else if (decode_advance) begin
                issue_sel[i] <= decode_inuse[i] ?
                    regfile_pkg::operand_src_t'(2'(decode_rs_wb_group[i])) :
                    regfile_pkg::SRC_BANK;
            end
        end
    end

    //////////////////////////////
    // Bypass capture
    //////////////////////////////

    // Keeps tracking commit data until the register goes free,
    // then freezes with the committed value
    always_ff @(posedge clk) begin
        for (int g = 0; g < `RF_NUM_WB_GROUPS; g++) begin
            for (int i = 0; i < `RF_READ_PORTS; i++) begin
                if (decode_advance | issue_inuse[i]) begin
                    commit_rs_data[g][i] <= commit_data[g];
                end
            end
        end
    end

    //////////////////////////////
    // Issue operand mux
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            case (issue_sel[i])
                regfile_pkg::SRC_WB_GROUP0: issue_data[i] = commit_rs_data[0][i];
                regfile_pkg::SRC_WB_GROUP1: issue_data[i] = commit_rs_data[1][i];
                default:                    issue_data[i] = rs_data_r[i];
            endcase
        end
    end

endmodule

// File: verilog/lutram_1w_mr.sv
`timescale 1ns/1ns
`include "regfile_cfg.svh"

module lutram_1w_mr #(
    parameter int WIDTH          = `RF_DATA_W,
    parameter int DEPTH          = `RF_NUM_PHYS_REGS,
    parameter int NUM_READ_PORTS = 2
) (
    input  logic                    clk,

    // Single write port
    input  regfile_pkg::phys_addr_t waddr,
    input  logic                    ram_write,
    input  logic [WIDTH-1:0]        new_ram_data,

    // Asynchronous read ports
    input  regfile_pkg::phys_addr_t raddr        [NUM_READ_PORTS],
    output logic [WIDTH-1:0]        ram_data_out [NUM_READ_PORTS]
);

    // Distributed RAM storage
    logic [WIDTH-1:0] ram [DEPTH];

    // Write lands on the clock edge
    always_ff @(posedge clk) begin
        if (ram_write) begin
            ram[waddr] <= new_ram_data;
        end
    end

    // Each read port is its own copy of the
    // LUTRAM address decode, no output register
    always_comb begin
        for (int r = 0; r < NUM_READ_PORTS; r++) begin
            ram_data_out[r] = ram[raddr[r]];
        end
    end

endmodule

// File: verilog/toggle_memory_set.sv
`timescale 1ns/1ns
`include "regfile_cfg.svh"

module toggle_memory_set #(
    parameter int DEPTH           = `RF_NUM_PHYS_REGS,
    parameter int NUM_WRITE_PORTS = 3,
    parameter int NUM_READ_PORTS  = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   init_clear,

    // Toggle strobes, one per write port
    input  logic                   toggle      [NUM_WRITE_PORTS],
    input  regfile_pkg::phys_addr_t toggle_addr [NUM_WRITE_PORTS],

    // Combinational in-use lookup
    input  regfile_pkg::phys_addr_t read_addr   [NUM_READ_PORTS],
    output logic                   in_use      [NUM_READ_PORTS]
);

    // One bit per entry
    typedef logic [DEPTH-1:0] bit_array_t;

    // Private array for each write port
    bit_array_t toggle_bits [NUM_WRITE_PORTS];

    // Combined view across all ports
    bit_array_t in_use_vec;

    // Any clear request
    logic clear_all;

    //////////////////////////////
    // Clear control
    //////////////////////////////

    // Reset and run-time init share the same path
    assign clear_all = reset | init_clear;

    //////////////////////////////
    // Toggle arrays
    //////////////////////////////

    // Each port only ever flips its own array
    // No two ports write the same storage, so no arbitration
    // A flip shows up on the read side next cycle
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WRITE_PORTS; w++) begin
            if (clear_all) begin
                // Every array back to zero, all entries free
                toggle_bits[w] <= '0;
            end else if (toggle[w]) begin
                toggle_bits[w][toggle_addr[w]] <= ~toggle_bits[w][toggle_addr[w]];
            end
        end
    end

    //////////////////////////////
    // In-use state
    //////////////////////////////

    // Entry is in use when an odd number of ports
    // have flipped it since the last clear
    // Set on one port, cleared on another, net zero
    always_comb begin
        in_use_vec = '0;
        for (int w = 0; w < NUM_WRITE_PORTS; w++) begin
            in_use_vec = in_use_vec ^ toggle_bits[w];
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    // Plain lookup into the combined vector
    // Same-cycle toggles are not forwarded
    always_comb begin
        for (int r = 0; r < NUM_READ_PORTS; r++) begin
            in_use[r] = in_use_vec[read_addr[r]];
        end
    end

endmodule

// File: verilog/regfile_pkg.sv
`include "regfile_cfg.svh"

package regfile_pkg;

    //////////////////////////////
    // Index types
    //////////////////////////////

    // Physical register index
    typedef logic [$clog2(`RF_NUM_PHYS_REGS)-1:0] phys_addr_t;

    // Writeback group index
    typedef logic [$clog2(`RF_NUM_WB_GROUPS)-1:0] wb_group_t;

    // Architectural register index, x0 to x31
    typedef logic [4:0] rs_addr_t;

    //////////////////////////////
    // Issue operand source
    //////////////////////////////

    // Group values line up with the group index
    // Bank takes the top code of the select
    typedef enum logic [1:0] {
        SRC_WB_GROUP0 = 2'd0,
        SRC_WB_GROUP1 = 2'd1,
        SRC_BANK      = 2'd3
    } operand_src_t;

endpackage

// File: verilog/regfile_cfg.svh
`ifndef REGFILE_CFG_SVH
`define REGFILE_CFG_SVH

//////////////////////////////
// Register file sizing
//////////////////////////////

// Physical registers shared by all groups
// Also sets the width of a physical index
`define RF_NUM_PHYS_REGS 64

// Data word width
`define RF_DATA_W 32

//////////////////////////////
// Port counts
//////////////////////////////

// Source operand ports, rs1 and rs2
`define RF_READ_PORTS 2

// Writeback groups, each with its own bank
// Group 0 is single cycle, group 1 is multi cycle
`define RF_NUM_WB_GROUPS 2

// Physical register 0 is hardwired to zero
// and never marked in use

`endif
